/* axi_delay_bridge.f */
axi_delay_pkg.sv
stretch_timer.sv
request_delayer.sv
response_delayer.sv
axi_delay_bridge.sv
tb_delay_checker.sv
tb_axi_delay_bridge.sv

/* tb_axi_delay_bridge.sv */
`timescale 1ns/1ps

module tb_axi_delay_bridge;

  import axi_delay_pkg::*;

  typedef struct packed {
    logic        is_write;
    logic [3:0]  id;
    logic [31:0] addr;
    logic [1:0]  len;
    logic [31:0] wdata;
    logic [3:0]  dn_wait;
    logic [3:0]  resp_lat;
    logic [1:0]  hold;       // Cycles of upstream back-pressure per beat
    logic [2:0]  exp_beats;
  } entry_t;

  localparam int N_TESTS = 8;

  logic clk;
  logic rst;
  logic [2:0] up_v;
  logic [2:0] dn_rdy;
  logic rsp_ready;
  logic test_end;
  int exp_beats;
  int errors;
  int cycles;
  int limit;
  entry_t tests [N_TESTS];

  addr_req_t up_ar_bits;
  addr_req_t up_aw_bits;
  wbeat_t up_w_bits;
  logic dn_r_valid;
  logic dn_b_valid;
  rbeat_t dn_r_bits;
  bresp_t dn_b_bits;

  logic up_ar_ready;
  logic up_aw_ready;
  logic up_w_ready;
  logic up_r_valid;
  logic up_b_valid;
  rbeat_t up_r_bits;
  bresp_t up_b_bits;
  logic dn_ar_valid;
  logic dn_aw_valid;
  logic dn_w_valid;
  logic dn_r_ready;
  logic dn_b_ready;
  addr_req_t dn_ar_bits;
  addr_req_t dn_aw_bits;
  wbeat_t dn_w_bits;

  wire up_ar_valid = up_v[0];
  wire up_aw_valid = up_v[1];
  wire up_w_valid = up_v[2];
  wire dn_ar_ready = dn_rdy[0];
  wire dn_aw_ready = dn_rdy[1];
  wire dn_w_ready = dn_rdy[2];
  wire up_r_ready = rsp_ready;
  wire up_b_ready = rsp_ready;
  wire [2:0] up_rdy = {up_w_ready, up_aw_ready, up_ar_ready};
  wire [2:0] dn_v = {dn_w_valid, dn_aw_valid, dn_ar_valid};
  wire cap = (dn_r_valid && dn_r_ready) || (dn_b_valid && dn_b_ready);
  wire dlv = (up_r_valid || up_b_valid) && rsp_ready;

  axi_delay_bridge uut (.*);
  tb_delay_checker chk (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("run stopped by timeout after %0d cycles", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic send_req(input int ch);
    up_v[ch] = 1'b1;
    do @(posedge clk); while (!up_rdy[ch]);
    @(negedge clk);
    up_v[ch] = 1'b0;
  endtask

  // Subordinate holds ready low for wt cycles of valid
  task automatic serve_req(input int ch, input int wt);
    int n;
    n = 0;
    dn_rdy[ch] = (wt == 0);
    while (n < wt) begin
      @(posedge clk);
      if (dn_v[ch] && !dn_rdy[ch]) n++;
    end
    if (wt > 0) begin
      @(negedge clk);
      dn_rdy[ch] = 1'b1;
    end
    do @(posedge clk); while (!(dn_v[ch] && dn_rdy[ch]));
    @(negedge clk);
    dn_rdy[ch] = 1'b0;
  endtask

  task automatic respond(input entry_t e, input int beats);
    fork
      begin
        for (int k = 0; k < beats; k++) begin
          repeat (e.resp_lat) @(negedge clk);
          if (e.is_write) begin
            dn_b_valid = 1'b1;
            dn_b_bits = '{id: e.id, resp: 2'b00};
          end else begin
            dn_r_valid = 1'b1;
            dn_r_bits = '{id: e.id, data: 32'(e.addr + k), resp: 2'b00,
                          last: (k == beats - 1)};
          end
          do @(posedge clk); while (!cap);
          @(negedge clk);
          dn_r_valid = 1'b0;
          dn_b_valid = 1'b0;
        end
      end
      begin
        for (int k = 0; k < beats; k++) begin
          if (e.hold != 0) begin
            do @(posedge clk); while (!cap);
            @(negedge clk);
            rsp_ready = 1'b0;
            do @(posedge clk); while (!(up_r_valid || up_b_valid));
            repeat (e.hold - 1) @(posedge clk);
            @(negedge clk);
            rsp_ready = 1'b1;
          end
          do @(posedge clk); while (!dlv);
        end
      end
    join
  endtask

  initial begin
    entry_t e;
    int n_pass;
    int n_fail;
    int err_before;
    tests[0] = '{1'b0, 4'h1, 32'h0000_1000, 2'd0, 32'h0, 4'd0, 4'd2, 2'd0, 3'd1};
    tests[1] = '{1'b0, 4'h2, 32'h0000_2000, 2'd1, 32'h0, 4'd2, 4'd1, 2'd0, 3'd2};
    tests[2] = '{1'b0, 4'h3, 32'h0000_3000, 2'd3, 32'h0, 4'd1, 4'd3, 2'd0, 3'd4};
    tests[3] = '{1'b1, 4'h4, 32'h0000_4000, 2'd0, 32'hcafe_0001, 4'd0, 4'd2, 2'd0, 3'd1};
    tests[4] = '{1'b1, 4'h5, 32'h0000_5000, 2'd0, 32'h1234_5678, 4'd3, 4'd0, 2'd0, 3'd1};
    tests[5] = '{1'b0, 4'h6, 32'h0000_6000, 2'd2, 32'h0, 4'd0, 4'd0, 2'd3, 3'd3};
    tests[6] = '{1'b1, 4'h7, 32'h0000_7000, 2'd0, 32'h0bad_f00d, 4'd1, 4'd1, 2'd2, 3'd1};
    tests[7] = '{1'b0, 4'h8, 32'h0000_8000, 2'd0, 32'h0, 4'd3, 4'd4, 2'd1, 3'd1};
    cycles = 0;
    limit = 100;
    for (int i = 0; i < N_TESTS; i++) begin
      limit += 3 * (int'(tests[i].dn_wait) + int'(tests[i].resp_lat) + 4) *
               (int'(tests[i].len) + 2);
    end
    rst = 1'b1;
    up_v = '0;
    dn_rdy = '0;
    rsp_ready = 1'b1;
    test_end = 1'b0;
    exp_beats = 0;
    up_ar_bits = '0;
    up_aw_bits = '0;
    up_w_bits = '0;
    dn_r_valid = 1'b0;
    dn_b_valid = 1'b0;
    dn_r_bits = '0;
    dn_b_bits = '0;
    n_pass = 0;
    n_fail = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);
    for (int i = 0; i < N_TESTS; i++) begin
      e = tests[i];
      err_before = errors;
      exp_beats = e.exp_beats;
      if (e.is_write) begin
        up_aw_bits = '{id: e.id, addr: e.addr, len: 8'd0, size: 3'd2, burst: 2'd1};
        up_w_bits = '{data: e.wdata, strb: 4'hf, last: 1'b1};
        fork
          send_req(1);
          serve_req(1, e.dn_wait);
          send_req(2);
          serve_req(2, e.dn_wait);
        join
        respond(e, 1);
      end else begin
        up_ar_bits = '{id: e.id, addr: e.addr, len: 8'(e.len), size: 3'd2, burst: 2'd1};
        fork
          send_req(0);
          serve_req(0, e.dn_wait);
        join
        respond(e, e.len + 1);
      end
      @(negedge clk);
      test_end = 1'b1;
      @(negedge clk);
      test_end = 1'b0;
      if (errors == err_before) n_pass++;
      else n_fail++;
      $display("test %0d %s id %h len %0d: %s", i, e.is_write ? "write" : "read", e.id,
               e.len, (errors == err_before) ? "ok" : "mismatch");
    end
    $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
    if (n_fail == 0 && errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* tb_delay_checker.sv */
`timescale 1ns/1ps

module tb_delay_checker (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     test_end,
  input  int                       exp_beats,
  output int                       errors,
  input  logic                     up_ar_valid,
  input  logic                     up_ar_ready,
  input  axi_delay_pkg::addr_req_t up_ar_bits,
  input  logic                     up_aw_valid,
  input  logic                     up_aw_ready,
  input  axi_delay_pkg::addr_req_t up_aw_bits,
  input  logic                     up_w_valid,
  input  logic                     up_w_ready,
  input  axi_delay_pkg::wbeat_t    up_w_bits,
  input  logic                     up_r_valid,
  input  logic                     up_r_ready,
  input  axi_delay_pkg::rbeat_t    up_r_bits,
  input  logic                     up_b_valid,
  input  logic                     up_b_ready,
  input  axi_delay_pkg::bresp_t    up_b_bits,
  input  logic                     dn_ar_valid,
  input  logic                     dn_ar_ready,
  input  axi_delay_pkg::addr_req_t dn_ar_bits,
  input  logic                     dn_aw_valid,
  input  logic                     dn_aw_ready,
  input  axi_delay_pkg::addr_req_t dn_aw_bits,
  input  logic                     dn_w_valid,
  input  logic                     dn_w_ready,
  input  axi_delay_pkg::wbeat_t    dn_w_bits,
  input  logic                     dn_r_valid,
  input  logic                     dn_r_ready,
  input  logic                     dn_b_valid,
  input  logic                     dn_b_ready
);

  import axi_delay_pkg::*;

  int          cyc;
  int          stall [3];
  int          exp_acc [3];
  bit          armed [3];
  int          last_clr [2];
  int          exp_valid [2];
  bit          holding [2];
  bit          seen [2];
  int          delivered;
  bit          rst_checked;
  logic [3:0]  rd_id;
  logic [31:0] rd_addr;
  int          rd_len;
  int          rd_beat;
  logic [3:0]  wr_id;

  // Bridge outputs that must be low straight after reset
  task automatic check_low(input string name, input logic v);
    if (v !== 1'b0) begin
      $display("error %s got %h expected 0", name, v);
      errors++;
    end
  endtask

  // Stalled downstream cycles set how long upstream ready is withheld
  task automatic track_req(input int ch, input string name, input logic uv, input logic ur,
                           input logic dv, input logic dr,
                           input logic [48:0] ub, input logic [48:0] db);
    if (dv && !dr) stall[ch]++;
    if (dv && dr) begin
      exp_acc[ch] = cyc + ((stall[ch] * EXTRA_Q10) >> FRAC_BITS);
      stall[ch] = 0;
      armed[ch] = 1'b1;
      if (db !== ub) begin
        $display("error dn_%s_bits got %h expected %h", name, db, ub);
        errors++;
      end
    end
    if (uv && ur) begin
      if (!armed[ch] || cyc != exp_acc[ch]) begin
        $display("%s accepted upstream at cycle %0d, expected cycle %0d", name, cyc,
                 exp_acc[ch]);
        errors++;
      end
      armed[ch] = 1'b0;
    end
  endtask

  task automatic track_rsp(input int ch, input string name, input logic clr,
                           input logic uv, input logic ur, input logic dv, input logic dr,
                           input logic [38:0] ub, input logic [38:0] expw);
    if (clr) last_clr[ch] = cyc;
    if (holding[ch]) begin
      if (dr) begin
        $display("dn_%s_ready went high while a beat was held", name);
        errors++;
      end
      if (uv) begin
        if (!seen[ch] && cyc != exp_valid[ch]) begin
          $display("up_%s_valid rose at cycle %0d, expected cycle %0d", name, cyc,
                   exp_valid[ch]);
          errors++;
        end
        seen[ch] = 1'b1;
        if (ub !== expw) begin
          $display("error up_%s_bits got %h expected %h", name, ub, expw);
          errors++;
        end
        if (ur) begin
          holding[ch] = 1'b0;
          delivered++;
          last_clr[ch] = cyc;
        end
      end else if (seen[ch]) begin
        $display("up_%s_valid dropped before the beat was delivered", name);
        errors++;
      end
    end else begin
      if (uv) begin
        $display("up_%s_valid high with no captured beat", name);
        errors++;
      end
      if (dv && dr) begin
        holding[ch] = 1'b1;
        seen[ch] = 1'b0;
        exp_valid[ch] = cyc + (((cyc - last_clr[ch]) * EXTRA_Q10) >> FRAC_BITS) + 1;
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      cyc = 0;
      errors = 0;
      delivered = 0;
      rst_checked = 1'b0;
      for (int i = 0; i < 3; i++) begin
        stall[i] = 0;
        armed[i] = 1'b0;
      end
      for (int i = 0; i < 2; i++) begin
        last_clr[i] = 0;
        holding[i] = 1'b0;
      end
    end else begin
      cyc++;
      if (!rst_checked) begin
        rst_checked = 1'b1;
        check_low("up_ar_ready", up_ar_ready);
        check_low("up_aw_ready", up_aw_ready);
        check_low("up_w_ready", up_w_ready);
        check_low("up_r_valid", up_r_valid);
        check_low("up_b_valid", up_b_valid);
        check_low("dn_ar_valid", dn_ar_valid);
        check_low("dn_aw_valid", dn_aw_valid);
        check_low("dn_w_valid", dn_w_valid);
      end
      track_req(0, "ar", up_ar_valid, up_ar_ready, dn_ar_valid, dn_ar_ready,
                up_ar_bits, dn_ar_bits);
      track_req(1, "aw", up_aw_valid, up_aw_ready, dn_aw_valid, dn_aw_ready,
                up_aw_bits, dn_aw_bits);
      track_req(2, "w", up_w_valid, up_w_ready, dn_w_valid, dn_w_ready,
                49'(up_w_bits), 49'(dn_w_bits));
      track_rsp(0, "r", up_ar_valid && up_ar_ready, up_r_valid, up_r_ready,
                dn_r_valid, dn_r_ready, up_r_bits,
                {rd_id, 32'(rd_addr + rd_beat), 2'b00, rd_beat == rd_len});
      track_rsp(1, "b", (up_aw_valid && up_aw_ready) || (up_w_valid && up_w_ready),
                up_b_valid, up_b_ready, dn_b_valid, dn_b_ready,
                {33'b0, up_b_bits}, {33'b0, wr_id, 2'b00});
      if (up_r_valid && up_r_ready) rd_beat++;
      if (up_ar_valid && up_ar_ready) begin
        rd_id = up_ar_bits.id;  // Model echoes id and returns addr plus beat
        rd_addr = up_ar_bits.addr;
        rd_len = up_ar_bits.len;
        rd_beat = 0;
      end
      if (up_aw_valid && up_aw_ready) wr_id = up_aw_bits.id;
      if (test_end) begin
        if (delivered != exp_beats) begin
          $display("%0d response beats delivered upstream, expected %0d", delivered,
                   exp_beats);
          errors++;
        end
        delivered = 0;
      end
    end
  end

endmodule

/* axi_delay_bridge.sv */
`timescale 1ns/1ps

module axi_delay_bridge (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     up_ar_valid,
  output logic                     up_ar_ready,
  input  axi_delay_pkg::addr_req_t up_ar_bits,
  input  logic                     up_aw_valid,
  output logic                     up_aw_ready,
  input  axi_delay_pkg::addr_req_t up_aw_bits,
  input  logic                     up_w_valid,
  output logic                     up_w_ready,
  input  axi_delay_pkg::wbeat_t    up_w_bits,
  output logic                     up_r_valid,
  input  logic                     up_r_ready,
  output axi_delay_pkg::rbeat_t    up_r_bits,
  output logic                     up_b_valid,
  input  logic                     up_b_ready,
  output axi_delay_pkg::bresp_t    up_b_bits,

  output logic                     dn_ar_valid,
  input  logic                     dn_ar_ready,
  output axi_delay_pkg::addr_req_t dn_ar_bits,
  output logic                     dn_aw_valid,
  input  logic                     dn_aw_ready,
  output axi_delay_pkg::addr_req_t dn_aw_bits,
  output logic                     dn_w_valid,
  input  logic                     dn_w_ready,
  output axi_delay_pkg::wbeat_t    dn_w_bits,
  input  logic                     dn_r_valid,
  output logic                     dn_r_ready,
  input  axi_delay_pkg::rbeat_t    dn_r_bits,
  input  logic                     dn_b_valid,
  output logic                     dn_b_ready,
  input  axi_delay_pkg::bresp_t    dn_b_bits
);

  import axi_delay_pkg::*;

  logic   ar_accepted;
  logic   aw_accepted;
  logic   w_accepted;
  logic   b_req_seen;
  rbeat_t dn_b_word;
  rbeat_t up_b_word;

  assign dn_ar_bits = up_ar_bits;
  assign dn_aw_bits = up_aw_bits;
  assign dn_w_bits  = up_w_bits;

  request_delayer u_ar_delayer (
    .clk      (clk),
    .rst      (rst),
    .up_valid (up_ar_valid),
    .up_ready (up_ar_ready),
    .dn_valid (dn_ar_valid),
    .dn_ready (dn_ar_ready),
    .accepted (ar_accepted)
  );

  request_delayer u_aw_delayer (
    .clk      (clk),
    .rst      (rst),
    .up_valid (up_aw_valid),
    .up_ready (up_aw_ready),
    .dn_valid (dn_aw_valid),
    .dn_ready (dn_aw_ready),
    .accepted (aw_accepted)
  );

  request_delayer u_w_delayer (
    .clk      (clk),
    .rst      (rst),
    .up_valid (up_w_valid),
    .up_ready (up_w_ready),
    .dn_valid (dn_w_valid),
    .dn_ready (dn_w_ready),
    .accepted (w_accepted)
  );

  response_delayer u_r_delayer (
    .clk      (clk),
    .rst      (rst),
    .req_seen (ar_accepted),  // Read latency counts from AR
    .dn_valid (dn_r_valid),
    .dn_ready (dn_r_ready),
    .dn_beat  (dn_r_bits),
    .up_valid (up_r_valid),
    .up_ready (up_r_ready),
    .up_beat  (up_r_bits)
  );

  // Write latency counts from the later of AW and W
  assign b_req_seen = aw_accepted || w_accepted;
  assign dn_b_word  = pack_bresp(dn_b_bits);
  assign up_b_bits  = unpack_bresp(up_b_word);

  response_delayer u_b_delayer (
    .clk      (clk),
    .rst      (rst),
    .req_seen (b_req_seen),
    .dn_valid (dn_b_valid),
    .dn_ready (dn_b_ready),
    .dn_beat  (dn_b_word),
    .up_valid (up_b_valid),
    .up_ready (up_b_ready),
    .up_beat  (up_b_word)
  );

endmodule

/* response_delayer.sv */
`timescale 1ns/1ps

module response_delayer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_seen,
  input  logic                  dn_valid,
  output logic                  dn_ready,
  input  axi_delay_pkg::rbeat_t dn_beat,
  output logic                  up_valid,
  input  logic                  up_ready,
  output axi_delay_pkg::rbeat_t up_beat
);

  import axi_delay_pkg::*;

  typedef enum logic {
    empty,
    hold
  } state_t;

  state_t state;
  rbeat_t beat_q;
  logic   capture;
  logic   deliver;
  logic   measuring;
  logic   timer_clear;
  logic   expired;

  // Subordinate only sees ready while nothing is held
  assign dn_ready = (state == empty) ? up_ready : 1'b0;
  assign capture  = dn_valid && dn_ready;

  assign up_valid = (state == hold) && expired;
  assign up_beat  = beat_q;
  assign deliver  = up_valid && up_ready;

  // Response time runs from the last request or delivery
  assign measuring   = (state == empty);
  assign timer_clear = req_seen || deliver;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= empty;
    end else begin
      case (state)
        empty: begin
          if (capture) begin
            state <= hold;
          end
        end
        default: begin
          if (deliver) begin
            state <= empty;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      beat_q <= dn_beat;  // Held unchanged until delivery
    end
  end

  stretch_timer u_timer (
    .clk        (clk),
    .rst        (rst),
    .accumulate (measuring),
    .clear      (timer_clear),
    .start      (capture),
    .expired    (expired)
  );

endmodule

/* request_delayer.sv */
`timescale 1ns/1ps

module request_delayer (
  input  logic clk,
  input  logic rst,
  input  logic up_valid,
  output logic up_ready,
  output logic dn_valid,
  input  logic dn_ready,
  output logic accepted
);

  typedef enum logic [1:0] {
    idle,
    wait_ready,
    stretch,
    done
  } state_t;

  state_t state;
  logic   dn_stall;
  logic   timer_clear;
  logic   expired;

  // Valid only reaches the subordinate before its handshake
  assign dn_valid = (state == idle || state == wait_ready) ? up_valid : 1'b0;
  assign dn_stall = dn_valid && !dn_ready;

  // Zero wait passes the ready through in the same cycle
  assign up_ready = (state == idle && up_valid && dn_ready) ||
                    (state == stretch && expired);
  assign accepted = up_valid && up_ready;

  assign timer_clear = (state == done);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (up_valid) begin
            state <= dn_ready ? done : wait_ready;
          end
        end
        wait_ready: begin
          if (dn_ready) begin
            state <= stretch;  // Downstream took it
          end
        end
        stretch: begin
          if (expired) begin
            state <= done;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // Countdown reloads with the running total on every stalled cycle
  stretch_timer u_timer (
    .clk        (clk),
    .rst        (rst),
    .accumulate (dn_stall),
    .clear      (timer_clear),
    .start      (dn_stall),
    .expired    (expired)
  );

endmodule

/* stretch_timer.sv */
`timescale 1ns/1ps

module stretch_timer (
  input  logic clk,
  input  logic rst,
  input  logic accumulate,
  input  logic clear,
  input  logic start,
  output logic expired
);

  import axi_delay_pkg::*;

  logic [ACC_W-1:0] acc;
  logic [ACC_W-1:0] acc_next;
  logic [CNT_W-1:0] count;

  // Fixed point sum of extra delay, Q10
  always_comb begin
    if (clear) begin
      acc_next = '0;
    end else if (accumulate) begin
      acc_next = acc + ACC_W'(EXTRA_Q10);
    end else begin
      acc_next = acc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      acc   <= '0;
      count <= '0;
    end else begin
      acc <= acc_next;
      if (start) begin
        count <= acc_next[ACC_W-1:FRAC_BITS];  // Whole cycles only
      end else if (count != '0) begin
        count <= count - 1'b1;
      end
    end
  end

  assign expired = (count == '0);

endmodule

/* axi_delay_pkg.sv */
package axi_delay_pkg;

  // AR and AW request fields
  typedef struct packed {
    logic [3:0]  id;
    logic [31:0] addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
  } addr_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
    logic        last;
  } wbeat_t;

  typedef struct packed {
    logic [3:0]  id;
    logic [31:0] data;
    logic [1:0]  resp;
    logic        last;
  } rbeat_t;

  typedef struct packed {
    logic [3:0] id;
    logic [1:0] resp;
  } bresp_t;

  localparam int DELAY_RATIO_Q10 = 3072;  // 3x slowdown
  localparam int FRAC_BITS       = 10;
  localparam int EXTRA_Q10       = DELAY_RATIO_Q10 - (1 << FRAC_BITS);
  localparam int ACC_W           = 32;
  localparam int CNT_W           = ACC_W - FRAC_BITS;  // Integer part of the accumulator

  localparam int RBEAT_W = $bits(rbeat_t);
  localparam int BRESP_W = $bits(bresp_t);

  // B response rides in the low bits of an R sized beat
  function automatic rbeat_t pack_bresp(bresp_t b);
    return rbeat_t'({{(RBEAT_W - BRESP_W){1'b0}}, b});
  endfunction

  function automatic bresp_t unpack_bresp(rbeat_t r);
    logic [RBEAT_W-1:0] word;
    word = r;
    return bresp_t'(word[BRESP_W-1:0]);
  endfunction

endpackage
